//--- verilog/crtcPkg.sv
package crtcPkg;

  localparam int maWidth = 14;
  localparam int raWidth = 5;

  typedef enum logic [4:0] {
    regHTotal    = 5'd0,
    regHDisp     = 5'd1,
    regHSyncPos  = 5'd2,
    regSyncWidth = 5'd3,
    regVTotal    = 5'd4,
    regVAdjust   = 5'd5,
    regVDisp     = 5'd6,
    regVSyncPos  = 5'd7,
    regMode      = 5'd8,
    regMaxRaster = 5'd9,
    regStartHi   = 5'd12,
    regStartLo   = 5'd13
  } regAddr_e;

  typedef struct packed {
    logic [7:0]         hTotal;
    logic [7:0]         hDisp;
    logic [7:0]         hSyncPos;
    logic [3:0]         hSyncWidth;
    logic [3:0]         vSyncWidth; // zero means 16 lines
    logic [6:0]         vTotal;
    logic [4:0]         vAdjust;
    logic [6:0]         vDisp;
    logic [6:0]         vSyncPos;
    logic [7:0]         mode;       // bits 5:4 are display skew
    logic [raWidth-1:0] maxRaster;
    logic [maWidth-1:0] startAddr;
  } crtcRegs_t;

  typedef struct packed {
    logic       csn;
    logic       rwn;
    logic       rs;
    logic [7:0] data;
  } busReq_t;

  localparam crtcRegs_t regResetVal = '{
    hTotal:     8'h3F,
    hDisp:      8'h28,
    hSyncPos:   8'h33,
    hSyncWidth: 4'h4,
    vSyncWidth: 4'h2,
    vTotal:     7'h1E,
    vAdjust:    5'h02,
    vDisp:      7'h19,
    vSyncPos:   7'h1B,
    mode:       8'h91,
    maxRaster:  5'h09,
    startAddr:  14'h2800
  };

endpackage

//--- verilog/mpuIf.sv
`timescale 1ns/1ns

module mpuIf (
  input  logic               I_CLK,
  input  logic               I_RSTn,
  input  logic               busStrobe,
  input  crtcPkg::busReq_t   busReq,
  output crtcPkg::crtcRegs_t regs
);

  import crtcPkg::*;

  logic [4:0] addrReg;
  logic       wrEn;
  regAddr_e   selReg;

  assign wrEn   = busStrobe & ~busReq.csn & ~busReq.rwn;
  assign selReg = regAddr_e'(addrReg); // unlisted indices fall to the default arm

  always_ff @(posedge I_CLK) begin
    if (!I_RSTn) begin
      addrReg <= '0;
      regs    <= regResetVal;
    end else if (wrEn) begin
      if (!busReq.rs) begin
        addrReg <= busReq.data[4:0];
      end else begin
        case (selReg)
          regHTotal: begin
            regs.hTotal <= busReq.data;
          end
          regHDisp: begin
            regs.hDisp <= busReq.data;
          end
          regHSyncPos: begin
            regs.hSyncPos <= busReq.data;
          end
          regSyncWidth: begin
            regs.hSyncWidth <= busReq.data[3:0]; // low nibble is horizontal
            regs.vSyncWidth <= busReq.data[7:4];
          end
          regVTotal: begin
            regs.vTotal <= busReq.data[6:0];
          end
          regVAdjust: begin
            regs.vAdjust <= busReq.data[4:0];
          end
          regVDisp: begin
            regs.vDisp <= busReq.data[6:0];
          end
          regVSyncPos: begin
            regs.vSyncPos <= busReq.data[6:0];
          end
          regMode: begin
            regs.mode <= busReq.data; // interlace and cursor skew bits kept as written
          end
          regMaxRaster: begin
            regs.maxRaster <= busReq.data[4:0];
          end
          regStartHi: begin
            regs.startAddr[13:8] <= busReq.data[5:0];
          end
          regStartLo: begin
            regs.startAddr[7:0] <= busReq.data;
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

//--- verilog/horizTiming.sv
`timescale 1ns/1ns

module horizTiming (
  input  logic               I_CLK,
  input  logic               I_RSTn,
  input  crtcPkg::crtcRegs_t regs,
  output logic               hDispRaw,
  output logic               hSync,
  output logic               lineEnd
);

  logic [7:0] hCount;
  logic [3:0] hSyncCnt;   // sync characters still to come after the current one
  logic       hSyncStart;

  // a compare with >= lets a lowered hTotal take effect on the next character
  assign lineEnd    = (hCount >= regs.hTotal);
  assign hDispRaw   = (hCount < regs.hDisp);
  assign hSyncStart = (hCount == regs.hSyncPos) && (regs.hSyncWidth != 4'd0);
  assign hSync      = hSyncStart | (hSyncCnt != 4'd0);

  always_ff @(posedge I_CLK) begin
    if (!I_RSTn) begin
      hCount <= '0;
    end else if (lineEnd) begin
      hCount <= '0;
    end else begin
      hCount <= hCount + 8'd1;
    end
  end

  always_ff @(posedge I_CLK) begin
    if (!I_RSTn) begin
      hSyncCnt <= '0;
    end else if (hSyncStart) begin
      hSyncCnt <= regs.hSyncWidth - 4'd1;
    end else if (hSyncCnt != 4'd0) begin
      hSyncCnt <= hSyncCnt - 4'd1;
    end
  end

endmodule

//--- verilog/vertTiming.sv
`timescale 1ns/1ns

module vertTiming (
  input  logic                        I_CLK,
  input  logic                        I_RSTn,
  input  crtcPkg::crtcRegs_t          regs,
  input  logic                        lineEnd,
  output logic [crtcPkg::raWidth-1:0] ra,
  output logic                        rowEnd,
  output logic                        frameStart,
  output logic                        vDispRaw,
  output logic                        vSync
);

  import crtcPkg::*;

  typedef enum logic {
    stRows,
    stAdjust
  } vtState_e;

  vtState_e           state;
  vtState_e           stateNext;
  logic [6:0]         row;
  logic [6:0]         rowNext;
  logic [raWidth-1:0] raNext;
  logic [4:0]         adjCount;  // number of the adjust line now running
  logic [4:0]         adjNext;
  logic [3:0]         vSyncCnt;
  logic               vSyncStart;

  assign rowEnd     = (state == stRows) && (ra >= regs.maxRaster);
  assign frameStart = (state == stRows) && (row == 7'd0) && (ra == '0);

  always_comb begin
    stateNext = state;
    rowNext   = row;
    raNext    = ra;
    adjNext   = adjCount;
    case (state)
      stRows: begin
        if (ra >= regs.maxRaster) begin
          raNext = '0;
          if (row >= regs.vTotal) begin
            rowNext = '0;
            if (regs.vAdjust != 5'd0) begin
              stateNext = stAdjust;
              adjNext   = 5'd1;
            end
          end else begin
            rowNext = row + 7'd1;
          end
        end else begin
          raNext = ra + raWidth'(1);
        end
      end
      stAdjust: begin
        if (adjCount >= regs.vAdjust) begin
          stateNext = stRows; // the next line opens a new frame
          adjNext   = '0;
        end else begin
          adjNext = adjCount + 5'd1;
        end
      end
      default: begin
        stateNext = stRows;
      end
    endcase
  end

  assign vSyncStart = (stateNext == stRows) && (rowNext == regs.vSyncPos) && (raNext == '0);

  always_ff @(posedge I_CLK) begin
    if (!I_RSTn) begin
      state    <= stRows;
      row      <= '0;
      ra       <= '0;
      adjCount <= '0;
      vDispRaw <= (regResetVal.vDisp != 7'd0);
      vSync    <= 1'b0;
      vSyncCnt <= '0;
    end else if (lineEnd) begin
      state    <= stateNext;
      row      <= rowNext;
      ra       <= raNext;
      adjCount <= adjNext;
      vDispRaw <= (stateNext == stRows) && (rowNext < regs.vDisp);
      if (vSyncStart) begin
        vSync    <= 1'b1;
        vSyncCnt <= regs.vSyncWidth - 4'd1; // a zero width wraps to 16 lines
      end else if (vSyncCnt != 4'd0) begin
        vSyncCnt <= vSyncCnt - 4'd1;
      end else begin
        vSync <= 1'b0;
      end
    end
  end

endmodule

//--- verilog/scanAddrGen.sv
`timescale 1ns/1ns

module scanAddrGen (
  input  logic                        I_CLK,
  input  logic                        I_RSTn,
  input  crtcPkg::crtcRegs_t          regs,
  input  logic                        hDispRaw,
  input  logic                        vDispRaw,
  input  logic                        lineEnd,
  input  logic                        rowEnd,
  input  logic                        frameStart,
  output logic [crtcPkg::maWidth-1:0] ma,
  output logic                        dispEn
);

  import crtcPkg::*;

  logic [maWidth-1:0] rowStart;
  logic [maWidth-1:0] lineBase;
  logic [maWidth-1:0] charOffset; // displayed characters so far in this line
  logic               dispRaw;
  logic [1:0]         dispDly;
  logic [1:0]         skew;

  // the first line of a frame always starts from the programmed start address
  assign lineBase = frameStart ? regs.startAddr : rowStart;
  assign ma       = lineBase + charOffset;

  always_ff @(posedge I_CLK) begin
    if (!I_RSTn) begin
      rowStart   <= regResetVal.startAddr;
      charOffset <= '0;
    end else if (lineEnd) begin
      charOffset <= '0;
      if (rowEnd) begin
        rowStart <= lineBase + maWidth'(regs.hDisp);
      end else begin
        rowStart <= lineBase;
      end
    end else if (hDispRaw) begin
      charOffset <= charOffset + maWidth'(1);
    end
  end

  assign dispRaw = hDispRaw & vDispRaw;
  assign skew    = regs.mode[5:4];

  always_ff @(posedge I_CLK) begin
    if (!I_RSTn) begin
      dispDly <= '0;
    end else begin
      dispDly <= {dispDly[0], dispRaw};
    end
  end

  always_comb begin
    case (skew)
      2'd0:    dispEn = dispRaw;
      2'd1:    dispEn = dispDly[0];
      2'd2:    dispEn = dispDly[1];
      default: dispEn = 1'b0; // skew 3 blanks the display
    endcase
  end

endmodule

//--- verilog/crtcTop.sv
`timescale 1ns/1ns

module crtcTop (
  input  logic                        I_CLK,
  input  logic                        I_RSTn,
  input  logic                        busStrobe,
  input  crtcPkg::busReq_t            busReq,
  output logic [crtcPkg::maWidth-1:0] ma,
  output logic [crtcPkg::raWidth-1:0] ra,
  output logic                        dispEn,
  output logic                        hSync,
  output logic                        vSync
);

  import crtcPkg::*;

  crtcRegs_t regs;
  logic      lineEnd;
  logic      hDispRaw;
  logic      vDispRaw;
  logic      rowEnd;
  logic      frameStart;

  mpuIf uMpuIf (
    .I_CLK     (I_CLK),
    .I_RSTn    (I_RSTn),
    .busStrobe (busStrobe),
    .busReq    (busReq),
    .regs      (regs)
  );

  horizTiming uHorizTiming (
    .I_CLK    (I_CLK),
    .I_RSTn   (I_RSTn),
    .regs     (regs),
    .hDispRaw (hDispRaw),
    .hSync    (hSync),
    .lineEnd  (lineEnd)
  );

  vertTiming uVertTiming (
    .I_CLK      (I_CLK),
    .I_RSTn     (I_RSTn),
    .regs       (regs),
    .lineEnd    (lineEnd),
    .ra         (ra),
    .rowEnd     (rowEnd),
    .frameStart (frameStart),
    .vDispRaw   (vDispRaw),
    .vSync      (vSync)
  );

  scanAddrGen uScanAddrGen (
    .I_CLK      (I_CLK),
    .I_RSTn     (I_RSTn),
    .regs       (regs),
    .hDispRaw   (hDispRaw),
    .vDispRaw   (vDispRaw),
    .lineEnd    (lineEnd),
    .rowEnd     (rowEnd),
    .frameStart (frameStart),
    .ma         (ma),
    .dispEn     (dispEn)
  );

endmodule

//--- test/crtcChecks.sv
`timescale 1ns/1ns

module crtcChecks (
  input  logic                        I_CLK,
  input  logic                        armed,
  input  crtcPkg::crtcRegs_t          expRegs,
  input  logic [crtcPkg::maWidth-1:0] ma,
  input  logic [crtcPkg::raWidth-1:0] ra,
  input  logic                        dispEn,
  input  logic                        hSync,
  input  logic                        vSync,
  output logic                        failed
);

  import crtcPkg::*;

  logic               hSyncQ;
  logic               vSyncQ;
  logic               hValid;   // character position locked to an hSync edge
  logic               vValid;   // line number locked to a vSync edge
  int                 hPos;
  int                 lineIdx;
  int                 rasters;
  int                 rowLines;
  int                 frameLen;
  int                 vsLine;
  int                 vsWidth;
  int                 skew;
  int                 row;
  int                 vsOffset;
  logic               hRise;
  logic               vRise;
  logic               hSyncExp;
  logic               vSyncExp;
  logic               lineShown;
  logic               dispExp;
  logic [raWidth-1:0] raExp;
  logic [maWidth-1:0] maExp;

  initial failed = 1'b0;

  assign rasters   = int'(expRegs.maxRaster) + 1;
  assign rowLines  = (int'(expRegs.vTotal) + 1) * rasters;
  assign frameLen  = rowLines + int'(expRegs.vAdjust);
  assign vsLine    = int'(expRegs.vSyncPos) * rasters;
  assign vsWidth   = (expRegs.vSyncWidth == 4'd0) ? 16 : int'(expRegs.vSyncWidth);
  assign skew      = int'(expRegs.mode[5:4]);
  assign hRise     = hSync & ~hSyncQ;
  assign vRise     = vSync & ~vSyncQ;
  assign row       = lineIdx / rasters;
  assign vsOffset  = (lineIdx + frameLen - vsLine) % frameLen;
  assign hSyncExp  = (hPos >= int'(expRegs.hSyncPos)) &&
                     (hPos < int'(expRegs.hSyncPos) + int'(expRegs.hSyncWidth));
  assign vSyncExp  = (vsOffset < vsWidth);
  assign lineShown = (lineIdx < rowLines) && (row < int'(expRegs.vDisp)); // adjust lines are blank
  assign dispExp   = (skew != 3) && lineShown && (hPos >= skew) &&
                     (hPos < int'(expRegs.hDisp) + skew);
  assign raExp     = raWidth'(lineIdx % rasters);
  assign maExp     = expRegs.startAddr + maWidth'(row * int'(expRegs.hDisp)) + maWidth'(hPos);

  always @(posedge I_CLK) begin
    hSyncQ <= hSync;
    vSyncQ <= vSync;
    if (!armed) begin
      hValid  <= 1'b0;
      vValid  <= 1'b0;
      hPos    <= 0;
      lineIdx <= 0;
    end else begin
      if (hRise && !hValid) begin
        hValid <= 1'b1;
        hPos   <= (int'(expRegs.hSyncPos) >= int'(expRegs.hTotal)) ? 0 :
                  int'(expRegs.hSyncPos) + 1;
      end else if (hValid) begin
        hPos <= (hPos >= int'(expRegs.hTotal)) ? 0 : hPos + 1;
      end
      if (hValid && vRise && !vValid) begin
        vValid  <= 1'b1;
        lineIdx <= vsLine; // vSync opens the first line of row vSyncPos
      end else if (vValid && hPos >= int'(expRegs.hTotal)) begin
        lineIdx <= (lineIdx + 1 >= frameLen) ? 0 : lineIdx + 1;
      end
    end
  end

  assert property (@(posedge I_CLK) disable iff (!armed) hValid |-> hSync == hSyncExp)
    else begin
      $display("MISMATCH hSync: got %h expected %h", $sampled(hSync), $sampled(hSyncExp));
      failed = 1'b1;
    end

  assert property (@(posedge I_CLK) disable iff (!armed) vValid |-> vSync == vSyncExp)
    else begin
      $display("MISMATCH vSync: got %h expected %h", $sampled(vSync), $sampled(vSyncExp));
      failed = 1'b1;
    end

  assert property (@(posedge I_CLK) disable iff (!armed)
                   (vValid && lineIdx < rowLines) |-> ra == raExp)
    else begin
      $display("MISMATCH ra: got %h expected %h", $sampled(ra), $sampled(raExp));
      failed = 1'b1;
    end

  assert property (@(posedge I_CLK) disable iff (!armed) vValid |-> dispEn == dispExp)
    else begin
      $display("MISMATCH dispEn: got %h expected %h", $sampled(dispEn), $sampled(dispExp));
      failed = 1'b1;
    end

  assert property (@(posedge I_CLK) disable iff (!armed)
                   (vValid && skew == 0 && dispExp) |-> ma == maExp)
    else begin
      $display("MISMATCH ma: got %h expected %h", $sampled(ma), $sampled(maExp));
      failed = 1'b1;
    end

endmodule

//--- test/crtcTb.sv
`timescale 1ns/1ns

module crtcTb;

  import crtcPkg::*;

  localparam int watchdogCycles = 64 * 312 * 4 + 40 * 16 * 16;

  logic               I_CLK;
  logic               I_RSTn;
  logic               busStrobe;
  busReq_t            busReq;
  logic [maWidth-1:0] ma;
  logic [raWidth-1:0] ra;
  logic               dispEn;
  logic               hSync;
  logic               vSync;
  logic               armed;
  logic               checkFail;
  crtcRegs_t          expRegs;

  crtcTop DUT (
    .I_CLK     (I_CLK),
    .I_RSTn    (I_RSTn),
    .busStrobe (busStrobe),
    .busReq    (busReq),
    .ma        (ma),
    .ra        (ra),
    .dispEn    (dispEn),
    .hSync     (hSync),
    .vSync     (vSync)
  );

  crtcChecks uChecks (
    .I_CLK   (I_CLK),
    .armed   (armed),
    .expRegs (expRegs),
    .ma      (ma),
    .ra      (ra),
    .dispEn  (dispEn),
    .hSync   (hSync),
    .vSync   (vSync),
    .failed  (checkFail)
  );

  initial begin
    I_CLK = 1'b0;
    forever #5 I_CLK = ~I_CLK;
  end

  task automatic stopWithFailure();
    $display("Test failed");
    $fatal(1);
  endtask

  always @(posedge checkFail) stopWithFailure();

  initial begin
    #(watchdogCycles * 10);
    $display("Timeout: the sequence did not finish within %0d cycles", watchdogCycles);
    stopWithFailure();
  end

  function automatic crtcRegs_t resetRegs();
    crtcRegs_t r;
    r = '{hTotal: 8'h3F, hDisp: 8'h28, hSyncPos: 8'h33, hSyncWidth: 4'h4,
          vSyncWidth: 4'h2, vTotal: 7'h1E, vAdjust: 5'h02, vDisp: 7'h19,
          vSyncPos: 7'h1B, mode: 8'h91, maxRaster: 5'h09, startAddr: 14'h2800};
    return r;
  endfunction

  // the register file model the checker compares against
  function automatic crtcRegs_t applyWrite(crtcRegs_t r, logic [4:0] idx, logic [7:0] d);
    case (idx)
      5'd0:    r.hTotal = d;
      5'd1:    r.hDisp = d;
      5'd2:    r.hSyncPos = d;
      5'd3:    {r.vSyncWidth, r.hSyncWidth} = d;
      5'd4:    r.vTotal = d[6:0];
      5'd5:    r.vAdjust = d[4:0];
      5'd6:    r.vDisp = d[6:0];
      5'd7:    r.vSyncPos = d[6:0];
      5'd8:    r.mode = d;
      5'd9:    r.maxRaster = d[4:0];
      5'd12:   r.startAddr[13:8] = d[5:0];
      5'd13:   r.startAddr[7:0] = d;
      default: r = r;
    endcase
    return r;
  endfunction

  task automatic writeReg(input logic [4:0] idx, input logic [7:0] d);
    @(posedge I_CLK);
    busStrobe <= 1'b1;
    busReq    <= '{csn: 1'b0, rwn: 1'b0, rs: 1'b0, data: {3'b000, idx}};
    @(posedge I_CLK);
    busReq    <= '{csn: 1'b0, rwn: 1'b0, rs: 1'b1, data: d};
    @(posedge I_CLK);
    busStrobe <= 1'b0;
    busReq    <= '{csn: 1'b1, rwn: 1'b1, rs: 1'b0, data: 8'h00};
    expRegs = applyWrite(expRegs, idx, d);
  endtask

  task automatic runConfig(input int hT, input int hP, input int hW, input int vT,
                           input int vA, input int vP, input int vW, input int skew,
                           input logic [13:0] start);
    armed <= 1'b0;
    writeReg(5'd0, 8'(hT));
    writeReg(5'd1, 8'd10);
    writeReg(5'd2, 8'(hP));
    writeReg(5'd3, {4'(vW), 4'(hW)});
    writeReg(5'd4, 8'(vT));
    writeReg(5'd5, 8'(vA));
    writeReg(5'd6, 8'd3);
    writeReg(5'd7, 8'(vP));
    writeReg(5'd8, {2'b00, 2'(skew), 4'h0});
    writeReg(5'd9, 8'd2); // three raster lines per row
    writeReg(5'd12, {2'b00, start[13:8]});
    writeReg(5'd13, start[7:0]);
    armed <= 1'b1;
    repeat (3) @(posedge vSync);
  endtask

  initial begin
    int hT;
    int hP;
    int hW;
    logic [13:0] start;
    void'($urandom(32'h2bd070d9));
    I_RSTn    = 1'b0;
    busStrobe = 1'b0;
    busReq    = '{csn: 1'b1, rwn: 1'b1, rs: 1'b0, data: 8'h00};
    armed     = 1'b0;
    expRegs   = resetRegs();
    repeat (4) @(posedge I_CLK);
    I_RSTn <= 1'b1;
    @(negedge I_CLK);
    assert (ma == 14'h2800) else begin
      $display("MISMATCH ma: got %h expected %h", ma, 14'h2800);
      stopWithFailure();
    end
    assert (dispEn == 1'b0) else begin
      $display("MISMATCH dispEn: got %h expected %h", dispEn, 1'b0);
      stopWithFailure();
    end
    assert (hSync == 1'b0) else begin
      $display("MISMATCH hSync: got %h expected %h", hSync, 1'b0);
      stopWithFailure();
    end
    assert (vSync == 1'b0) else begin
      $display("MISMATCH vSync: got %h expected %h", vSync, 1'b0);
      stopWithFailure();
    end
    @(posedge I_CLK);
    armed <= 1'b1;
    repeat (2) @(posedge vSync); // one whole frame of the reset geometry
    start = 14'($urandom);
    for (int s = 0; s < 4; s++) begin
      runConfig(15, 12, 2, 3, 1, 3, 2, s, start);
    end
    for (int i = 0; i < 6; i++) begin
      hT    = $urandom_range(24, 12);
      hP    = $urandom_range(hT - 1, 0);
      hW    = $urandom_range((hT - hP > 15) ? 15 : hT - hP, 1);
      start = 14'($urandom);
      runConfig(hT, hP, hW, 3, 1, 3, 2, 0, start);
    end
    runConfig(15, 12, 2, 7, 2, 1, 0, 0, start); // taller frame for a 16 line vSync
    if (checkFail) begin
      stopWithFailure();
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

//--- crtc.f
verilog/crtcPkg.sv
verilog/mpuIf.sv
verilog/horizTiming.sv
verilog/vertTiming.sv
verilog/scanAddrGen.sv
verilog/crtcTop.sv
test/crtcChecks.sv
test/crtcTb.sv
